// ==== src/GpioPortPkg.sv ====
// GPIO port package with bus widths, register offsets, select codes and bus word helpers.
package GpioPortPkg;

    localparam int BusWidth  = 16;
    localparam int PinCount  = 16;
    localparam int HalfWidth = 8;
    localparam int AltCount  = 3;

    // Register offsets from the port base.
    localparam logic [BusWidth-1:0] OffsIn   = 16'h0000;
    localparam logic [BusWidth-1:0] OffsOut  = 16'h0002;
    localparam logic [BusWidth-1:0] OffsDir  = 16'h0004;
    localparam logic [BusWidth-1:0] OffsRen  = 16'h0006;
    localparam logic [BusWidth-1:0] OffsSel0 = 16'h000A;
    localparam logic [BusWidth-1:0] OffsSel1 = 16'h000C;
    localparam logic [BusWidth-1:0] OffsIes  = 16'h0018;
    localparam logic [BusWidth-1:0] OffsIe   = 16'h001A;
    localparam logic [BusWidth-1:0] OffsIfg  = 16'h001C;

    typedef logic [1:0] PinSel;

    localparam PinSel SelIo = 2'd0; // Plain I/O.

    typedef union packed {
        logic [BusWidth-1:0] Word;
        struct packed {
            logic [HalfWidth-1:0] HalfY; // Pins 15..8.
            logic [HalfWidth-1:0] HalfX; // Pins 7..0.
        } Halves;
    } BusWord;

    // Byte writes always carry the data in the low byte.
    function automatic BusWord mergeWrite(BusWord cur, BusWord wdata, logic byteAcc,
                                          logic hiByte);
        BusWord result;
        result = cur;
        if (!byteAcc) result.Word = wdata.Word;
        else if (hiByte) result.Halves.HalfY = wdata.Halves.HalfX;
        else result.Halves.HalfX = wdata.Halves.HalfX;
        return result;
    endfunction

    function automatic BusWord readView(BusWord value, logic byteAcc, logic hiByte);
        BusWord result;
        result.Word = '0;
        if (!byteAcc) result = value;
        else if (hiByte) result.Halves.HalfX = value.Halves.HalfY; // Upper byte lands low.
        else result.Halves.HalfX = value.Halves.HalfX;
        return result;
    endfunction

endpackage

// ==== src/PortRegisters.sv ====
// Port register block holding output, direction, pull-enable and function-select words.
`timescale 1ns/100ps

module PortRegisters #(
    parameter logic [GpioPortPkg::BusWidth-1:0] BaseAddr = 16'h0200
) (
    input  logic                                SysClock,
    input  logic                                BSLenter,
    input  logic [GpioPortPkg::BusWidth-1:0]    Mab,
    input  GpioPortPkg::BusWord                 MdbWrite,
    input  logic                                Mw,
    input  logic                                Bw,
    output GpioPortPkg::BusWord                 RdData,
    output logic [GpioPortPkg::PinCount-1:0]    OutReg,
    output logic [GpioPortPkg::PinCount-1:0]    DirReg,
    output logic [GpioPortPkg::PinCount-1:0]    RenReg,
    output logic [GpioPortPkg::PinCount-1:0]    Sel0Reg,
    output logic [GpioPortPkg::PinCount-1:0]    Sel1Reg
);

    import GpioPortPkg::*;

    logic [BusWidth-1:0] WordAddr;
    logic                HiByte;
    logic                HitOut;
    logic                HitDir;
    logic                HitRen;
    logic                HitSel0;
    logic                HitSel1;
    BusWord              OutQ;
    BusWord              DirQ;
    BusWord              RenQ;
    BusWord              Sel0Q;
    BusWord              Sel1Q;
    BusWord              RdSel;

    assign WordAddr = {Mab[BusWidth-1:1], 1'b0}; // Byte accesses may be odd.
    assign HiByte   = Mab[0];

    assign HitOut  = (WordAddr == BaseAddr + OffsOut);
    assign HitDir  = (WordAddr == BaseAddr + OffsDir);
    assign HitRen  = (WordAddr == BaseAddr + OffsRen);
    assign HitSel0 = (WordAddr == BaseAddr + OffsSel0);
    assign HitSel1 = (WordAddr == BaseAddr + OffsSel1);

    always_ff @(posedge SysClock or posedge BSLenter) begin
        if (BSLenter) begin
            OutQ  <= '0;
            DirQ  <= '0; // All pins come up as inputs.
            RenQ  <= '0;
            Sel0Q <= '0;
            Sel1Q <= '0;
        end else if (Mw) begin
            if (HitOut) begin
                OutQ <= mergeWrite(OutQ, MdbWrite, Bw, HiByte);
            end
            if (HitDir) begin
                DirQ <= mergeWrite(DirQ, MdbWrite, Bw, HiByte);
            end
            if (HitRen) begin
                RenQ <= mergeWrite(RenQ, MdbWrite, Bw, HiByte);
            end
            if (HitSel0) begin
                Sel0Q <= mergeWrite(Sel0Q, MdbWrite, Bw, HiByte);
            end
            if (HitSel1) begin
                Sel1Q <= mergeWrite(Sel1Q, MdbWrite, Bw, HiByte);
            end
        end
    end

    // Combinational read, zero when no register of ours is addressed.
    always_comb begin
        RdSel.Word = '0;
        if (HitOut) begin
            RdSel = OutQ;
        end else if (HitDir) begin
            RdSel = DirQ;
        end else if (HitRen) begin
            RdSel = RenQ;
        end else if (HitSel0) begin
            RdSel = Sel0Q;
        end else if (HitSel1) begin
            RdSel = Sel1Q;
        end
    end

    assign RdData = readView(RdSel, Bw, HiByte);

    assign OutReg  = OutQ.Word;
    assign DirReg  = DirQ.Word;
    assign RenReg  = RenQ.Word;
    assign Sel0Reg = Sel0Q.Word;
    assign Sel1Reg = Sel1Q.Word;

endmodule

// ==== src/PinCell.sv ====
// Pin cell that picks the pad drive source, output enable and pull, and routes the pad input.
`timescale 1ns/100ps

module PinCell (
    input  logic                                OutBit,
    input  logic                                DirBit,
    input  logic                                RenBit,
    input  GpioPortPkg::PinSel                  Sel,
    input  logic [GpioPortPkg::AltCount-1:0]    AltOut,
    input  logic [GpioPortPkg::AltCount-1:0]    AltDir,
    input  logic                                PadIn,
    output logic [GpioPortPkg::AltCount-1:0]    AltIn,
    output logic                                PadOut,
    output logic                                PadOe,
    output logic                                PadPullEn,
    output logic                                PadInBit
);

    import GpioPortPkg::*;

    // Code k selects alternate function k at index k-1.
    always_comb begin
        PadOut = OutBit;
        PadOe  = DirBit;
        if (Sel != SelIo) begin
            PadOut = AltOut[Sel - 2'd1];
            PadOe  = AltDir[Sel - 2'd1];
        end
    end

    // Pull only on an undriven pad; PadOut then gives up or down.
    assign PadPullEn = RenBit & ~PadOe;

    always_comb begin
        for (int k = 0; k < AltCount; k++) begin
            AltIn[k] = PadIn & (Sel == PinSel'(k + 1));
        end
    end

    assign PadInBit = PadIn;

endmodule

// ==== src/PortInterrupts.sv ====
// Pad input capture with edge-select, enable and flag registers for the two half-port interrupts.
`timescale 1ns/100ps

module PortInterrupts #(
    parameter logic [GpioPortPkg::BusWidth-1:0] BaseAddr = 16'h0200
) (
    input  logic                                SysClock,
    input  logic                                BSLenter,
    input  logic [GpioPortPkg::BusWidth-1:0]    Mab,
    input  GpioPortPkg::BusWord                 MdbWrite,
    input  logic                                Mw,
    input  logic                                Bw,
    input  logic [GpioPortPkg::PinCount-1:0]    PadInBit,
    output GpioPortPkg::BusWord                 RdData,
    output logic                                PxInt,
    output logic                                PyInt
);

    import GpioPortPkg::*;

    logic [BusWidth-1:0] WordAddr;
    logic                HiByte;
    logic                HitIn;
    logic                HitIes;
    logic                HitIe;
    logic                HitIfg;
    BusWord              InReg;
    BusWord              InPrev;
    BusWord              IesQ;
    BusWord              IeQ;
    BusWord              IfgQ;
    BusWord              IfgBase;
    BusWord              RdSel;
    logic [PinCount-1:0] EdgeHit;
    logic [PinCount-1:0] Pending;

    assign WordAddr = {Mab[BusWidth-1:1], 1'b0};
    assign HiByte   = Mab[0];

    assign HitIn  = (WordAddr == BaseAddr + OffsIn);
    assign HitIes = (WordAddr == BaseAddr + OffsIes);
    assign HitIe  = (WordAddr == BaseAddr + OffsIe);
    assign HitIfg = (WordAddr == BaseAddr + OffsIfg);

    // Ies low picks rising, high picks falling.
    assign EdgeHit = (InReg.Word & ~InPrev.Word & ~IesQ.Word)
                   | (~InReg.Word & InPrev.Word & IesQ.Word);

    always_comb begin
        IfgBase = IfgQ;
        if (Mw && HitIfg) begin
            IfgBase = mergeWrite(IfgQ, MdbWrite, Bw, HiByte); // Software clear path.
        end
    end

    always_ff @(posedge SysClock or posedge BSLenter) begin
        if (BSLenter) begin
            InReg  <= '0;
            InPrev <= '0;
            IesQ   <= '0;
            IeQ    <= '0;
            IfgQ   <= '0;
        end else begin
            InReg.Word  <= PadInBit; // Sampled every edge.
            InPrev      <= InReg;
            IfgQ.Word   <= IfgBase.Word | EdgeHit; // Edge wins over a same-cycle write.
            if (Mw && HitIes) begin
                IesQ <= mergeWrite(IesQ, MdbWrite, Bw, HiByte);
            end
            if (Mw && HitIe) begin
                IeQ <= mergeWrite(IeQ, MdbWrite, Bw, HiByte);
            end
        end
    end

    always_comb begin
        RdSel.Word = '0;
        if (HitIn) begin
            RdSel = InReg;
        end else if (HitIes) begin
            RdSel = IesQ;
        end else if (HitIe) begin
            RdSel = IeQ;
        end else if (HitIfg) begin
            RdSel = IfgQ;
        end
    end

    assign RdData = readView(RdSel, Bw, HiByte);

    assign Pending = IfgQ.Word & IeQ.Word;
    assign PxInt   = |Pending[HalfWidth-1:0];
    assign PyInt   = |Pending[PinCount-1:HalfWidth];

endmodule

// ==== src/GpioPort.sv ====
// Sixteen-pin GPIO port top level joining the register block, pin cells and interrupt logic.
`timescale 1ns/100ps

module GpioPort #(
    parameter logic [GpioPortPkg::BusWidth-1:0] BaseAddr = 16'h0200
) (
    input  logic                                SysClock,
    input  logic                                BSLenter,
    input  logic [GpioPortPkg::BusWidth-1:0]    Mab,
    input  GpioPortPkg::BusWord                 MdbWrite,
    input  logic                                Mw,
    input  logic                                Bw,
    input  logic [GpioPortPkg::PinCount-1:0]    PadIn,
    input  logic [GpioPortPkg::PinCount-1:0]    AltOut1,
    input  logic [GpioPortPkg::PinCount-1:0]    AltOut2,
    input  logic [GpioPortPkg::PinCount-1:0]    AltOut3,
    input  logic [GpioPortPkg::PinCount-1:0]    AltDir1,
    input  logic [GpioPortPkg::PinCount-1:0]    AltDir2,
    input  logic [GpioPortPkg::PinCount-1:0]    AltDir3,
    output GpioPortPkg::BusWord                 MdbRead,
    output logic [GpioPortPkg::PinCount-1:0]    PadOut,
    output logic [GpioPortPkg::PinCount-1:0]    PadOe,
    output logic [GpioPortPkg::PinCount-1:0]    PadPullEn,
    output logic [GpioPortPkg::PinCount-1:0]    AltIn1,
    output logic [GpioPortPkg::PinCount-1:0]    AltIn2,
    output logic [GpioPortPkg::PinCount-1:0]    AltIn3,
    output logic                                PxInt,
    output logic                                PyInt
);

    import GpioPortPkg::*;

    BusWord              RegRdData;
    BusWord              IntRdData;
    logic [PinCount-1:0] OutReg;
    logic [PinCount-1:0] DirReg;
    logic [PinCount-1:0] RenReg;
    logic [PinCount-1:0] Sel0Reg;
    logic [PinCount-1:0] Sel1Reg;
    logic [PinCount-1:0] PadInBit;
    logic [AltCount-1:0] PinAltIn [PinCount];

    PortRegisters #(.BaseAddr(BaseAddr)) regs (
        .SysClock(SysClock), .BSLenter(BSLenter),
        .Mab(Mab), .MdbWrite(MdbWrite), .Mw(Mw), .Bw(Bw),
        .RdData(RegRdData),
        .OutReg(OutReg), .DirReg(DirReg), .RenReg(RenReg),
        .Sel0Reg(Sel0Reg), .Sel1Reg(Sel1Reg)
    );

    for (genvar i = 0; i < PinCount; i++) begin : gPin
        PinCell pin (
            .OutBit(OutReg[i]), .DirBit(DirReg[i]), .RenBit(RenReg[i]),
            .Sel({Sel1Reg[i], Sel0Reg[i]}), // Sel1 is the high bit.
            .AltOut({AltOut3[i], AltOut2[i], AltOut1[i]}),
            .AltDir({AltDir3[i], AltDir2[i], AltDir1[i]}),
            .PadIn(PadIn[i]),
            .AltIn(PinAltIn[i]),
            .PadOut(PadOut[i]), .PadOe(PadOe[i]), .PadPullEn(PadPullEn[i]),
            .PadInBit(PadInBit[i])
        );
        assign AltIn1[i] = PinAltIn[i][0];
        assign AltIn2[i] = PinAltIn[i][1];
        assign AltIn3[i] = PinAltIn[i][2];
    end

    PortInterrupts #(.BaseAddr(BaseAddr)) ints (
        .SysClock(SysClock), .BSLenter(BSLenter),
        .Mab(Mab), .MdbWrite(MdbWrite), .Mw(Mw), .Bw(Bw),
        .PadInBit(PadInBit),
        .RdData(IntRdData),
        .PxInt(PxInt), .PyInt(PyInt)
    );

    assign MdbRead.Word = RegRdData.Word | IntRdData.Word; // Unaddressed block reads zero.

endmodule

// ==== verif/GpioPortTb.sv ====
// Directed testbench for the GPIO port covering registers, pin muxing and pin interrupts.
`timescale 1ns/100ps

module GpioPortTb;

    import GpioPortPkg::*;

    localparam logic [BusWidth-1:0] BaseAddr = 16'h0200;
    localparam int MaxCycles = 2000; // Tests need about 300 cycles.

    logic                SysClock;
    logic                BSLenter;
    logic [BusWidth-1:0] Mab;
    BusWord              MdbWrite;
    logic                Mw;
    logic                Bw;
    logic [PinCount-1:0] PadIn;
    logic [PinCount-1:0] AltOut1;
    logic [PinCount-1:0] AltOut2;
    logic [PinCount-1:0] AltOut3;
    logic [PinCount-1:0] AltDir1;
    logic [PinCount-1:0] AltDir2;
    logic [PinCount-1:0] AltDir3;
    BusWord              MdbRead;
    logic [PinCount-1:0] PadOut;
    logic [PinCount-1:0] PadOe;
    logic [PinCount-1:0] PadPullEn;
    logic [PinCount-1:0] AltIn1;
    logic [PinCount-1:0] AltIn2;
    logic [PinCount-1:0] AltIn3;
    logic                PxInt;
    logic                PyInt;
    logic [PinCount-1:0] OutVal;
    logic [PinCount-1:0] DirVal;
    logic [PinCount-1:0] RenVal;
    int                  CycleCount = 0;

    GpioPort #(.BaseAddr(BaseAddr)) uut (
        .SysClock(SysClock), .BSLenter(BSLenter),
        .Mab(Mab), .MdbWrite(MdbWrite), .Mw(Mw), .Bw(Bw), .PadIn(PadIn),
        .AltOut1(AltOut1), .AltOut2(AltOut2), .AltOut3(AltOut3),
        .AltDir1(AltDir1), .AltDir2(AltDir2), .AltDir3(AltDir3),
        .MdbRead(MdbRead), .PadOut(PadOut), .PadOe(PadOe), .PadPullEn(PadPullEn),
        .AltIn1(AltIn1), .AltIn2(AltIn2), .AltIn3(AltIn3),
        .PxInt(PxInt), .PyInt(PyInt)
    );

    initial begin
        SysClock = 1'b0;
        forever #2 SysClock = ~SysClock;
    end

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("TESTS FAILED");
        $fatal(1, "run stopped");
    endtask

    always @(posedge SysClock) begin
        CycleCount = CycleCount + 1;
        if (CycleCount > MaxCycles) begin
            abortRun($sformatf("timeout, tests did not finish in %0d clock cycles", MaxCycles));
        end
    end

    function automatic logic [PinCount-1:0] randWord();
        logic [31:0] r;
        r = $urandom();
        return r[PinCount-1:0];
    endfunction

    task automatic checkWord(input string name, input BusWord got, input BusWord exp);
        if (got.Word !== exp.Word) begin
            abortRun($sformatf("mismatch at %0d ns: %s is %h, expected %h",
                               $time, name, got.Word, exp.Word));
        end
    endtask

    task automatic checkVec(input string name, input logic [PinCount-1:0] got,
                            input logic [PinCount-1:0] exp);
        if (got !== exp) begin
            abortRun($sformatf("mismatch at %0d ns: %s is %h, expected %h",
                               $time, name, got, exp));
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abortRun($sformatf("mismatch at %0d ns: %s is %b, expected %b",
                               $time, name, got, exp));
        end
    endtask

    // Write lands on the second edge; returns just after it.
    task automatic busWrite(input logic [BusWidth-1:0] addr, input BusWord data,
                            input logic isByte);
        @(posedge SysClock);
        #1;
        Mab      = addr;
        MdbWrite = data;
        Bw       = isByte;
        Mw       = 1'b1;
        @(posedge SysClock);
        #1;
        Mw = 1'b0;
        Bw = 1'b0;
    endtask

    task automatic busRead(input logic [BusWidth-1:0] addr, input logic isByte,
                           output BusWord data);
        @(posedge SysClock);
        #1;
        Mab = addr;
        Bw  = isByte;
        Mw  = 1'b0;
        @(negedge SysClock); // Read path is combinational.
        data = MdbRead;
    endtask

    task automatic resetTest();
        BusWord              rd;
        BusWord              zero;
        logic [BusWidth-1:0] offs [9];
        zero.Word = '0;
        offs = '{OffsIn, OffsOut, OffsDir, OffsRen, OffsSel0, OffsSel1, OffsIes, OffsIe, OffsIfg};
        foreach (offs[i]) begin
            busRead(BaseAddr + offs[i], 1'b0, rd);
            checkWord($sformatf("register %h", BaseAddr + offs[i]), rd, zero);
        end
        checkVec("PadOut", PadOut, '0);
        checkVec("PadOe", PadOe, '0);
        checkVec("PadPullEn", PadPullEn, '0);
        checkBit("PxInt", PxInt, 1'b0);
        checkBit("PyInt", PyInt, 1'b0);
    endtask

    task automatic accessRegister(input string name, input logic [BusWidth-1:0] addr);
        BusWord wr;
        BusWord rd;
        BusWord exp;
        BusWord byteExp;
        wr.Word = randWord();
        busWrite(addr, wr, 1'b0);
        busRead(addr, 1'b0, rd);
        checkWord(name, rd, wr);
        exp = wr;
        wr.Word = randWord(); // High byte of the data must be ignored.
        exp.Halves.HalfX = wr.Halves.HalfX;
        busWrite(addr, wr, 1'b1);
        busRead(addr, 1'b0, rd);
        checkWord({name, " after low byte write"}, rd, exp);
        wr.Word = randWord();
        exp.Halves.HalfY = wr.Halves.HalfX;
        busWrite(addr + 16'd1, wr, 1'b1);
        busRead(addr, 1'b0, rd);
        checkWord({name, " after high byte write"}, rd, exp);
        byteExp.Word = {{HalfWidth{1'b0}}, exp.Halves.HalfX};
        busRead(addr, 1'b1, rd);
        checkWord({name, " low byte read"}, rd, byteExp);
        byteExp.Word = {{HalfWidth{1'b0}}, exp.Halves.HalfY};
        busRead(addr + 16'd1, 1'b1, rd);
        checkWord({name, " high byte read"}, rd, byteExp);
    endtask

    task automatic registerTest();
        accessRegister("Out", BaseAddr + OffsOut);
        accessRegister("Dir", BaseAddr + OffsDir);
        accessRegister("Ren", BaseAddr + OffsRen);
        accessRegister("Sel0", BaseAddr + OffsSel0);
        accessRegister("Sel1", BaseAddr + OffsSel1);
        accessRegister("Ies", BaseAddr + OffsIes);
        accessRegister("Ie", BaseAddr + OffsIe);
    endtask

    task automatic pinIoTest();
        BusWord wr;
        BusWord rd;
        BusWord exp;
        wr.Word = '0;
        busWrite(BaseAddr + OffsSel0, wr, 1'b0);
        busWrite(BaseAddr + OffsSel1, wr, 1'b0);
        OutVal = randWord();
        DirVal = randWord();
        RenVal = randWord();
        wr.Word = OutVal;
        busWrite(BaseAddr + OffsOut, wr, 1'b0);
        wr.Word = DirVal;
        busWrite(BaseAddr + OffsDir, wr, 1'b0);
        wr.Word = RenVal;
        busWrite(BaseAddr + OffsRen, wr, 1'b0);
        @(negedge SysClock);
        checkVec("PadOut", PadOut, OutVal);
        checkVec("PadOe", PadOe, DirVal);
        checkVec("PadPullEn", PadPullEn, RenVal & ~DirVal);
        @(posedge SysClock);
        #1;
        PadIn = randWord();
        repeat (2) @(posedge SysClock);
        busRead(BaseAddr + OffsIn, 1'b0, rd);
        exp.Word = PadIn;
        checkWord("In", rd, exp);
    endtask

    task automatic altFunctionTest();
        BusWord              wr;
        logic [PinCount-1:0] sel0;
        logic [PinCount-1:0] sel1;
        logic [PinCount-1:0] expOut;
        logic [PinCount-1:0] expOe;
        logic [PinCount-1:0] expIn1;
        logic [PinCount-1:0] expIn2;
        logic [PinCount-1:0] expIn3;
        logic [1:0]          code;
        for (int round = 0; round < 4; round++) begin
            sel0 = randWord();
            sel1 = randWord();
            wr.Word = sel0;
            busWrite(BaseAddr + OffsSel0, wr, 1'b0);
            wr.Word = sel1;
            busWrite(BaseAddr + OffsSel1, wr, 1'b0);
            @(posedge SysClock);
            #1;
            AltOut1 = randWord();
            AltOut2 = randWord();
            AltOut3 = randWord();
            AltDir1 = randWord();
            AltDir2 = randWord();
            AltDir3 = randWord();
            PadIn   = randWord();
            for (int i = 0; i < PinCount; i++) begin
                code = {sel1[i], sel0[i]};
                case (code)
                    2'd0: begin
                        expOut[i] = OutVal[i];
                        expOe[i]  = DirVal[i];
                    end
                    2'd1: begin
                        expOut[i] = AltOut1[i];
                        expOe[i]  = AltDir1[i];
                    end
                    2'd2: begin
                        expOut[i] = AltOut2[i];
                        expOe[i]  = AltDir2[i];
                    end
                    default: begin
                        expOut[i] = AltOut3[i];
                        expOe[i]  = AltDir3[i];
                    end
                endcase
                expIn1[i] = PadIn[i] & (code == 2'd1);
                expIn2[i] = PadIn[i] & (code == 2'd2);
                expIn3[i] = PadIn[i] & (code == 2'd3);
            end
            @(negedge SysClock);
            checkVec("PadOut", PadOut, expOut);
            checkVec("PadOe", PadOe, expOe);
            checkVec("PadPullEn", PadPullEn, RenVal & ~expOe);
            checkVec("AltIn1", AltIn1, expIn1);
            checkVec("AltIn2", AltIn2, expIn2);
            checkVec("AltIn3", AltIn3, expIn3);
        end
    endtask

    // Waits one edge more than pad to flag needs.
    task automatic setPads(input logic [PinCount-1:0] level);
        @(posedge SysClock);
        #1;
        PadIn = level;
        repeat (3) @(posedge SysClock);
    endtask

    task automatic expectFlags(input logic [PinCount-1:0] flags, input logic xLine,
                               input logic yLine);
        BusWord rd;
        BusWord exp;
        exp.Word = flags;
        busRead(BaseAddr + OffsIfg, 1'b0, rd);
        checkWord("Ifg", rd, exp);
        checkBit("PxInt", PxInt, xLine);
        checkBit("PyInt", PyInt, yLine);
    endtask

    task automatic clearFlags();
        BusWord wr;
        wr.Word = '0;
        busWrite(BaseAddr + OffsIfg, wr, 1'b0);
    endtask

    task automatic interruptTest();
        BusWord wr;
        wr.Word = '0;
        busWrite(BaseAddr + OffsIe, wr, 1'b0);
        setPads('0);
        clearFlags();
        wr.Word = 16'h0800; // Pin 11 falling, the rest rising.
        busWrite(BaseAddr + OffsIes, wr, 1'b0);
        wr.Word = 16'h0804;
        busWrite(BaseAddr + OffsIe, wr, 1'b0);
        setPads(16'h2004); // Pin 13 rises but stays masked.
        expectFlags(16'h2004, 1'b1, 1'b0);
        clearFlags();
        expectFlags(16'h0000, 1'b0, 1'b0);
        setPads(16'h0000);
        expectFlags(16'h0000, 1'b0, 1'b0);
        setPads(16'h0800);
        expectFlags(16'h0000, 1'b0, 1'b0);
        setPads(16'h0000);
        expectFlags(16'h0800, 1'b0, 1'b1);
        clearFlags();
        expectFlags(16'h0000, 1'b0, 1'b0);
    endtask

    initial begin
        void'($urandom(32'hc4d7_1ea0));
        BSLenter      = 1'b1;
        Mab           = '0;
        MdbWrite.Word = '0;
        Mw            = 1'b0;
        Bw            = 1'b0;
        PadIn         = '0;
        AltOut1       = '0;
        AltOut2       = '0;
        AltOut3       = '0;
        AltDir1       = '0;
        AltDir2       = '0;
        AltDir3       = '0;
        OutVal        = '0;
        DirVal        = '0;
        RenVal        = '0;
        repeat (3) @(posedge SysClock);
        #1;
        BSLenter = 1'b0;
        resetTest();
        registerTest();
        pinIoTest();
        altFunctionTest();
        interruptTest();
        $display("TESTS PASSED");
        $finish;
    end

endmodule

// ==== GpioPort.f ====
src/GpioPortPkg.sv
src/PortRegisters.sv
src/PinCell.sv
src/PortInterrupts.sv
src/GpioPort.sv
verif/GpioPortTb.sv

// ==== Bender.yml ====
package:
  name: gpio_port

sources:
  - src/GpioPortPkg.sv
  - src/PortRegisters.sv
  - src/PinCell.sv
  - src/PortInterrupts.sv
  - src/GpioPort.sv
  - target: test
    files:
      - verif/GpioPortTb.sv
